// File: intCore_trace.txt
# instr(hex) rd(dec) value(hex) illegal(0/1), one test per line in program order
# Values follow RV32I, illegal ops expect rd 0 and value 0
800000B7 1 80000000 0
FFF08093 1 7FFFFFFF 0
00100113 2 00000001 0
002081B3 3 80000000 0
40110233 4 80000002 0
0021A2B3 5 00000001 0
0021B333 6 00000000 0
02300393 7 00000023 0
00711433 8 00000008 0
4071D4B3 9 F0000000 0
0071D533 10 10000000 0
00A4C5B3 11 E0000000 0
0025E633 12 E0000001 0
001676B3 13 60000001 0
FFF6C713 14 9FFFFFFE 0
FFE72793 15 00000001 0
FFF13813 16 00000001 0
00510013 0 00000006 0
002008B3 17 00000001 0
0041013B 0 00000000 1
00010913 18 00000001 0
021089B3 0 00000000 1
12345A37 20 12345000 0
800A0A13 20 12344800 0
401A0AB3 21 92344801 0
404ADB13 22 F9234480 0
01CB5B93 23 0000000F 0
01CB9C13 24 F0000000 0
80006C93 25 FFFFF800 0
FF0C7D13 26 F0000000 0
019D0DB3 27 EFFFF800 0

// File: vlog.f
+incdir+.
intCorePkg.sv
pipeReg.sv
regFile.sv
decodeStage.sv
executeStage.sv
intCore.sv
resultChecker.sv
tbIntCore.sv

// File: runSim.sh
#!/bin/sh
# Build and run the intCore testbench with Verilator, from the project root
verilator --binary --timing --timescale 1ns/10ps -f vlog.f --top-module tbIntCore \
  -Mdir obj_dir -o simIntCore &&
  ./obj_dir/simIntCore | tee sim.log &&
  grep -qx "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tbIntCore.sv
////////////////////////////////////////
// Trace-driven testbench for intCore
// Run from the project root to find the trace
////////////////////////////////////////

`timescale 1ns/10ps

module tbIntCore;

  localparam int unsigned waitLimit   = 200;
  localparam int unsigned resetCycles = 8;

  logic                clk = 1'b0;
  logic                reset = 1'b1;
  logic [31:0]         instr = '0;
  logic                instrValid = 1'b0;
  logic                instrReady;
  intCorePkg::retire_t retire;
  logic                retireValid;
  logic                retireReady = 1'b0;
  logic [31:0]         instrQ [$];
  int unsigned         testCount = 0;
  int unsigned         tbErrors = 0;
  bit                  abortRun = 1'b0;

  intCore uut (
    .clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid),
    .instrReady(instrReady), .retire(retire), .retireValid(retireValid),
    .retireReady(retireReady)
  );

  resultChecker chk (
    .clk(clk), .reset(reset), .retire(retire), .retireValid(retireValid),
    .retireReady(retireReady)
  );

  always #5 clk = ~clk;

  // Retire back-pressure, ready about 70% of cycles
  always @(posedge clk) begin
    #1;
    retireReady = (($urandom % 10) < 7);
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  // Instructions go to the local queue, results to the checker
  task automatic loadTrace();
    int                  fd;
    int                  code;
    string               line;
    logic [31:0]         ins;
    int unsigned         expRd;
    logic [31:0]         expVal;
    int unsigned         expIll;
    intCorePkg::retire_t entry;
    fd = $fopen("intCore_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file intCore_trace.txt");
      tbErrors++;
      abortRun = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if ((code > 0) && (line.getc(0) != "#")) begin
        code = $sscanf(line, "%h %d %h %d", ins, expRd, expVal, expIll);
        if (code == 4) begin
          entry.rd      = expRd[4:0];
          entry.result  = expVal;
          entry.illegal = expIll[0];
          instrQ.push_back(ins);
          chk.expQ.push_back(entry);
        end
      end
    end
    $fclose(fd);
    testCount = instrQ.size();
  endtask

  // One instruction per handshake, random idle gaps between them
  task automatic driveAll();
    int unsigned gap;
    int unsigned waited;
    bit          accepted;
    for (int unsigned i = 0; (i < testCount) && !abortRun; i++) begin
      instr      = instrQ[i];
      instrValid = 1'b1;
      accepted   = 1'b0;
      waited     = 0;
      while (!accepted && (waited < waitLimit)) begin
        // Ready seen here means a transfer at the next rising edge
        @(negedge clk);
        accepted = instrReady;
        @(posedge clk);
        #1;
        waited++;
      end
      instrValid = 1'b0;
      if (!accepted) begin
        $display("Instruction %0d was never accepted by the DUT", i);
        tbErrors++;
        abortRun = 1'b1;
      end else begin
        gap = $urandom % 3;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
    end
  endtask

  // Wait for every expected result, then a few cycles for strays
  task automatic drainRetire();
    int unsigned waited;
    waited = 0;
    while ((chk.expQ.size() != 0) && (waited < waitLimit)) begin
      @(posedge clk);
      waited++;
    end
    if (chk.expQ.size() != 0) begin
      $display("%0d results never retired from the DUT", chk.expQ.size());
      tbErrors++;
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic finishRun();
    $display("Summary: %0d passed, %0d failed, %0d other errors",
             chk.passCount, chk.failCount, tbErrors);
    if ((chk.failCount == 0) && (tbErrors == 0) && (testCount > 0) &&
        (chk.passCount == testCount)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'ha078_8295));
    loadTrace();
    repeat (resetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
    if (!abortRun) driveAll();
    if (!abortRun) drainRetire();
    finishRun();
  end

endmodule

// File: resultChecker.sv
////////////////////////////////////////
// Retire stream checker, in-order compare
// Expected entries are pushed by the testbench
////////////////////////////////////////

`timescale 1ns/10ps

module resultChecker (
  input logic                clk,
  input logic                reset,
  input intCorePkg::retire_t retire,
  input logic                retireValid,
  input logic                retireReady
);

  // Expected results in program order
  intCorePkg::retire_t expQ [$];
  intCorePkg::retire_t expEntry;
  int unsigned         passCount = 0;
  int unsigned         failCount = 0;
  int unsigned         testIdx = 0;

  // Inputs settle 1 ns after the rising edge, so the falling edge is safe
  always @(negedge clk) begin
    if (!reset && retireValid && retireReady) begin
      if (expQ.size() == 0) begin
        $display("Extra result retired at %0t with no test left to match it", $time);
        failCount++;
      end else begin
        expEntry = expQ.pop_front();
        if (retire === expEntry) begin
          $display("Test %0d passed: rd %0d value %h illegal %0b",
                   testIdx, retire.rd, retire.result, retire.illegal);
          passCount++;
        end else begin
          $display("Mismatch at %0t: test %0d expected rd %0d value %h illegal %0b, %s",
                   $time, testIdx, expEntry.rd, expEntry.result, expEntry.illegal,
                   $sformatf("got rd %0d value %h illegal %0b",
                             retire.rd, retire.result, retire.illegal));
          failCount++;
        end
        testIdx++;
      end
    end
  end

endmodule

// File: intCore.sv
////////////////////////////////////////
// Two-stage in-order integer core, 2-cycle latency
// Stalls only on retire back-pressure
////////////////////////////////////////

`timescale 1ns/10ps
`include "intCore_defs.svh"

module intCore (
  input  logic                clk,
  input  logic                reset,
  // Instruction stream
  input  logic [31:0]         instr,
  input  logic                instrValid,
  output logic                instrReady,
  // Retire stream
  output intCorePkg::retire_t retire,
  output logic                retireValid,
  input  logic                retireReady
);

  // Register file read path
  logic [4:0]               rs1;
  logic [4:0]               rs2;
  logic [`INTCORE_XLEN-1:0] rd1;
  logic [`INTCORE_XLEN-1:0] rd2;
  // Decode side of deReg
  intCorePkg::decodedOp_t   decodedD;
  // Execute side of deReg
  intCorePkg::decodedOp_t   decodedE;
  logic                     decodedValidE;
  logic                     ewReady;
  // Execute result into ewReg
  intCorePkg::retire_t      resultE;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  decodeStage decode (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2), .decoded(decodedD)
  );

  pipeReg #(.payload_t(intCorePkg::decodedOp_t)) deReg (
    .clk(clk), .reset(reset),
    .inData(decodedD), .inValid(instrValid), .inReady(instrReady),
    .outData(decodedE), .outValid(decodedValidE), .outReady(ewReady)
  );

  ////////////////////////////////////////
  // Execute and writeback
  ////////////////////////////////////////

  // Writeback register output doubles as the bypass source
  executeStage execute (
    .decoded(decodedE), .bypass(retire), .bypassValid(retireValid), .result(resultE)
  );

  pipeReg #(.payload_t(intCorePkg::retire_t)) ewReg (
    .clk(clk), .reset(reset),
    .inData(resultE), .inValid(decodedValidE), .inReady(ewReady),
    .outData(retire), .outValid(retireValid), .outReady(retireReady)
  );

  // Written on each retire transfer
  regFile regs (
    .clk(clk), .reset(reset),
    .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
    .commit(retire), .commitValid(retireValid), .commitReady(retireReady)
  );

endmodule

// File: executeStage.sv
////////////////////////////////////////
// Operand forwarding and ALU
// Bypass comes only from the writeback register
////////////////////////////////////////

`timescale 1ns/10ps
`include "intCore_defs.svh"

module executeStage (
  // Payload from the decode/execute register
  input  intCorePkg::decodedOp_t decoded,
  // Writeback register contents
  input  intCorePkg::retire_t    bypass,
  input  logic                   bypassValid,
  // Toward the writeback register
  output intCorePkg::retire_t    result
);

  logic [`INTCORE_XLEN-1:0] opA;
  logic [`INTCORE_XLEN-1:0] opB;
  logic [`INTCORE_XLEN-1:0] srcA;
  logic [`INTCORE_XLEN-1:0] srcB;
  logic [`INTCORE_XLEN-1:0] aluOut;
  logic [4:0]               shamt;
  logic                     ltSigned;
  logic                     ltUnsigned;

  ////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////

  // Newer result in writeback beats the value read in decode
  function automatic logic [`INTCORE_XLEN-1:0] forwardOperand(
    input logic [4:0]               idx,
    input logic [`INTCORE_XLEN-1:0] readVal,
    input intCorePkg::retire_t      byp,
    input logic                     bypValid
  );
    logic hit;
    hit = bypValid && !byp.illegal && (byp.rd != 5'd0) && (byp.rd == idx);
    return hit ? byp.result : readVal;
  endfunction

  assign opA = forwardOperand(decoded.rs1, decoded.rd1, bypass, bypassValid);
  assign opB = forwardOperand(decoded.rs2, decoded.rd2, bypass, bypassValid);

  ////////////////////////////////////////
  // Source selection
  ////////////////////////////////////////

  // Zero A for LUI
  assign srcA = decoded.srcAZero ? '0 : opA;
  // Immediate B for I-type and LUI
  assign srcB = decoded.srcBImm ? decoded.extImm : opB;

  // RV32I masks shift amounts to 5 bits
  assign shamt = srcB[4:0];

  assign ltSigned   = $signed(srcA) < $signed(srcB);
  assign ltUnsigned = srcA < srcB;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    case (decoded.aluOp)
      intCorePkg::aluAdd:  aluOut = srcA + srcB;
      intCorePkg::aluSub:  aluOut = srcA - srcB;
      intCorePkg::aluSll:  aluOut = srcA << shamt;
      intCorePkg::aluSlt:  aluOut = {{(`INTCORE_XLEN-1){1'b0}}, ltSigned};
      intCorePkg::aluSltu: aluOut = {{(`INTCORE_XLEN-1){1'b0}}, ltUnsigned};
      intCorePkg::aluXor:  aluOut = srcA ^ srcB;
      intCorePkg::aluSrl:  aluOut = srcA >> shamt;
      // Arithmetic shift keeps the sign bit
      intCorePkg::aluSra:  aluOut = $unsigned($signed(srcA) >>> shamt);
      intCorePkg::aluOr:   aluOut = srcA | srcB;
      intCorePkg::aluAnd:  aluOut = srcA & srcB;
      default:             aluOut = srcB;
    endcase
  end

  ////////////////////////////////////////
  // Result payload
  ////////////////////////////////////////

  // rd already zero for illegal ops, value forced here
  always_comb begin
    result.rd      = decoded.rd;
    result.result  = decoded.illegal ? '0 : aluOut;
    result.illegal = decoded.illegal;
  end

endmodule

// File: decodeStage.sv
////////////////////////////////////////
// RV32I ALU-op and LUI decoder
// Anything else decodes as illegal, rd 0
////////////////////////////////////////

`timescale 1ns/10ps
`include "intCore_defs.svh"

module decodeStage (
  input  logic [31:0]               instr,
  // Register file read ports
  output logic [4:0]                rs1,
  output logic [4:0]                rs2,
  input  logic [`INTCORE_XLEN-1:0]  rd1,
  input  logic [`INTCORE_XLEN-1:0]  rd2,
  // Payload toward execute
  output intCorePkg::decodedOp_t    decoded
);

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [`INTCORE_XLEN-1:0] immI;
  logic [`INTCORE_XLEN-1:0] immU;
  intCorePkg::aluOp_t       aluOp;
  logic                     illegal;
  logic                     isLui;

  ////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // I-type sign extension, U-type fills the upper 20 bits
  assign immI  = {{(`INTCORE_XLEN-12){instr[31]}}, instr[31:20]};
  assign immU  = {instr[31:12], 12'b0};
  assign isLui = (opcode == `INTCORE_OP_LUI);

  ////////////////////////////////////////
  // ALU op selection
  ////////////////////////////////////////

  always_comb begin
    aluOp   = intCorePkg::aluPassB;
    illegal = 1'b0;
    case (opcode)
      `INTCORE_OP_REG: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'd0: aluOp = intCorePkg::aluAdd;
            3'd1: aluOp = intCorePkg::aluSll;
            3'd2: aluOp = intCorePkg::aluSlt;
            3'd3: aluOp = intCorePkg::aluSltu;
            3'd4: aluOp = intCorePkg::aluXor;
            3'd5: aluOp = intCorePkg::aluSrl;
            3'd6: aluOp = intCorePkg::aluOr;
            default: aluOp = intCorePkg::aluAnd;
          endcase
        end else if ((funct7 == 7'b0100000) && (funct3 == 3'd0)) begin
          aluOp = intCorePkg::aluSub;
        end else if ((funct7 == 7'b0100000) && (funct3 == 3'd5)) begin
          aluOp = intCorePkg::aluSra;
        end else begin
          illegal = 1'b1;
        end
      end
      `INTCORE_OP_IMM: begin
        case (funct3)
          3'd0: aluOp = intCorePkg::aluAdd;
          3'd2: aluOp = intCorePkg::aluSlt;
          3'd3: aluOp = intCorePkg::aluSltu;
          3'd4: aluOp = intCorePkg::aluXor;
          3'd6: aluOp = intCorePkg::aluOr;
          3'd7: aluOp = intCorePkg::aluAnd;
          // Shifts keep funct7 in the immediate's upper bits
          3'd1: begin
            aluOp   = intCorePkg::aluSll;
            illegal = (funct7 != 7'b0000000);
          end
          default: begin
            if (funct7 == 7'b0000000) aluOp = intCorePkg::aluSrl;
            else if (funct7 == 7'b0100000) aluOp = intCorePkg::aluSra;
            else illegal = 1'b1;
          end
        endcase
      end
      // LUI adds the U immediate to a zero source A
      `INTCORE_OP_LUI: aluOp = intCorePkg::aluAdd;
      default: illegal = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // Payload assembly
  ////////////////////////////////////////

  always_comb begin
    decoded.rs1      = rs1;
    decoded.rs2      = rs2;
    // Illegal ops must never look like a writer
    decoded.rd       = illegal ? 5'd0 : instr[11:7];
    decoded.rd1      = rd1;
    decoded.rd2      = rd2;
    decoded.extImm   = isLui ? immU : immI;
    decoded.aluOp    = aluOp;
    decoded.srcAZero = isLui;
    decoded.srcBImm  = (opcode != `INTCORE_OP_REG);
    decoded.illegal  = illegal;
  end

endmodule

// File: regFile.sv
////////////////////////////////////////
// 32-entry register file, x0 reads zero
// Same-cycle write is visible on reads
////////////////////////////////////////

`timescale 1ns/10ps
`include "intCore_defs.svh"

module regFile (
  input  logic                     clk,
  input  logic                     reset,
  // Decode read ports
  input  logic [4:0]               rs1,
  input  logic [4:0]               rs2,
  output logic [`INTCORE_XLEN-1:0] rd1,
  output logic [`INTCORE_XLEN-1:0] rd2,
  // Retire stream, watched for writes
  input  intCorePkg::retire_t      commit,
  input  logic                     commitValid,
  input  logic                     commitReady
);

  logic [`INTCORE_XLEN-1:0] regs [`INTCORE_NREGS];
  logic                     writeEn;

  // Read with x0 tie-off and write-through from the commit port
  function automatic logic [`INTCORE_XLEN-1:0] readPort(
    input logic [4:0]               idx,
    input logic [`INTCORE_XLEN-1:0] stored,
    input logic                     we,
    input intCorePkg::retire_t      wr
  );
    if (idx == 5'd0) return '0;
    if (we && (wr.rd == idx)) return wr.result;
    return stored;
  endfunction

  // Only a real transfer of a legal, non-x0 result writes
  assign writeEn = commitValid && commitReady && !commit.illegal && (commit.rd != 5'd0);

  // Entry 0 is cleared here and never written again
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `INTCORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[commit.rd] <= commit.result;
    end
  end

  assign rd1 = readPort(rs1, regs[rs1], writeEn, commit);
  assign rd2 = readPort(rs2, regs[rs2], writeEn, commit);

endmodule

// File: pipeReg.sv
////////////////////////////////////////
// One-entry valid/ready stage register
// Ready passes back combinationally
////////////////////////////////////////

`timescale 1ns/10ps

module pipeReg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  // Upstream side
  input  payload_t inData,
  input  logic     inValid,
  output logic     inReady,
  // Downstream side
  output payload_t outData,
  output logic     outValid,
  input  logic     outReady
);

  logic     full;
  logic     loadEn;
  payload_t dataQ;

  // Accept when empty or when the held entry leaves this cycle
  assign inReady = !full || outReady;
  assign loadEn  = inValid && inReady;

  // Occupancy flag
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (loadEn) begin
      full <= 1'b1;
    end else if (outReady) begin
      // Drained with nothing new behind it
      full <= 1'b0;
    end
  end

  // Payload only moves on a load
  always_ff @(posedge clk) begin
    if (loadEn) begin
      dataQ <= inData;
    end
  end

  assign outData  = dataQ;
  assign outValid = full;

endmodule

// File: intCorePkg.sv
////////////////////////////////////////
// Types shared by the pipeline stages
// Register indices are fixed at 5 bits
////////////////////////////////////////

`include "intCore_defs.svh"

package intCorePkg;

  ////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////

  // One code per RV32I ALU function
  // PassB forwards source B unchanged
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassB
  } aluOp_t;

  ////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////

  // Decode to execute
  typedef struct packed {
    // Source and destination indices
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic [4:0]               rd;
    // Register values read in decode, may be stale
    logic [`INTCORE_XLEN-1:0] rd1;
    logic [`INTCORE_XLEN-1:0] rd2;
    // Sign-extended I or U immediate
    logic [`INTCORE_XLEN-1:0] extImm;
    aluOp_t                   aluOp;
    // Source A forced to zero (LUI)
    logic                     srcAZero;
    // Source B taken from the immediate
    logic                     srcBImm;
    logic                     illegal;
  } decodedOp_t;

  // Execute to writeback, also the retire stream
  typedef struct packed {
    // Zero for illegal ops and x0 writes
    logic [4:0]               rd;
    logic [`INTCORE_XLEN-1:0] result;
    logic                     illegal;
  } retire_t;

endpackage

// File: intCore_defs.svh
////////////////////////////////////////
// Sizes and opcodes shared by the integer core
// Immediate extension assumes a 32-bit datapath
////////////////////////////////////////

`ifndef INTCORE_DEFS_SVH
`define INTCORE_DEFS_SVH

////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////

// Integer register and ALU width
`define INTCORE_XLEN 32

// Architectural registers, x0 included
`define INTCORE_NREGS 32

////////////////////////////////////////
// RV32I major opcodes, instr[6:0]
////////////////////////////////////////

// Register-register ALU group
`define INTCORE_OP_REG 7'b0110011

// Register-immediate ALU group
`define INTCORE_OP_IMM 7'b0010011

// Load upper immediate
`define INTCORE_OP_LUI 7'b0110111

`endif
